// ==== dv/l2_stub.sv ====
// L2 cache model for the store path testbench
// Acks each request after a set delay and answers one cycle after the ack

`timescale 1ns/10ps

module l2_stub (
	input logic clk,
	input logic rst_n_i,
	input logic pci_valid_i,
	input l1_store_pkg::strand_id_t pci_strand_i,
	input logic [7:0] ack_delay_i,
	input logic status_i,
	input logic update_i,
	output logic pci_ack_o,
	output logic cpi_valid_o,
	output logic cpi_status_o,
	output l1_store_pkg::unit_id_t cpi_unit_o,
	output l1_store_pkg::strand_id_t cpi_strand_o,
	output l1_store_pkg::resp_op_t cpi_op_o,
	output logic cpi_update_o,
	output logic [7:0] req_count_o
);

	logic [7:0] wait_cnt;

	assign cpi_unit_o = l1_store_pkg::STBUF_UNIT;
	assign cpi_op_o = '0;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			pci_ack_o <= 1'b0;
			cpi_valid_o <= 1'b0;
			cpi_status_o <= 1'b0;
			cpi_strand_o <= '0;
			cpi_update_o <= 1'b0;
			wait_cnt <= '0;
			req_count_o <= '0;
		end
		else
		begin
			cpi_valid_o <= 1'b0;
			if (pci_ack_o)
			begin
				// Ack cycle is over, respond in the next one
				pci_ack_o <= 1'b0;
				wait_cnt <= '0;
				cpi_valid_o <= 1'b1;
				cpi_strand_o <= pci_strand_i;
				cpi_status_o <= status_i;
				cpi_update_o <= update_i;
				req_count_o <= req_count_o + 8'd1;
			end
			else if (pci_valid_i)
			begin
				if (wait_cnt >= ack_delay_i)
				begin
					pci_ack_o <= 1'b1;
				end
				else
				begin
					wait_cnt <= wait_cnt + 8'd1;
				end
			end
		end
	end

endmodule

// ==== dv/store_path_tb.sv ====
// Testbench for the L1 data cache store path
// Table-driven stores, lookups and L2 drains against an L2 model

`timescale 1ns/10ps

module store_path_tb;

	typedef enum logic [1:0] {ROW_STORE, ROW_SYNC, ROW_LOAD, ROW_DRAIN} row_op_t;
	typedef enum logic [1:0] {CHK_NONE, CHK_ZERO, CHK_HIT, CHK_SYNC} check_t;

	typedef struct packed
	{
		row_op_t op;
		l1_store_pkg::strand_id_t strand;
		l1_store_pkg::tag_t tag;
		l1_store_pkg::set_t set_idx;
		l1_store_pkg::line_data_t data;
		l1_store_pkg::byte_mask_t mask;
		logic [7:0] delay;
		logic status;
		logic update;
		logic enq;
		logic exp_rollback;
		check_t chk;
		l1_store_pkg::strand_mask_t exp_resume;
	} stim_row_t;

	localparam int WAIT_LIMIT = 100;

	logic clk;
	logic rst_n;
	logic write;
	logic synchronized;
	l1_store_pkg::strand_id_t strand_id;
	l1_store_pkg::tag_t tag;
	l1_store_pkg::set_t set_idx;
	l1_store_pkg::line_data_t data_in;
	l1_store_pkg::byte_mask_t mask_in;
	l1_store_pkg::line_data_t data_out;
	l1_store_pkg::byte_mask_t mask_out;
	logic rollback;
	l1_store_pkg::strand_mask_t resume_strands;
	logic store_update;
	l1_store_pkg::set_t store_update_set;
	logic pci_valid;
	logic pci_ack;
	l1_store_pkg::unit_id_t pci_unit;
	l1_store_pkg::strand_id_t pci_strand;
	l1_store_pkg::l2_op_t pci_op;
	l1_store_pkg::line_addr_t pci_address;
	l1_store_pkg::line_data_t pci_data;
	l1_store_pkg::byte_mask_t pci_mask;
	logic cpi_valid;
	logic cpi_status;
	l1_store_pkg::unit_id_t cpi_unit;
	l1_store_pkg::strand_id_t cpi_strand;
	l1_store_pkg::resp_op_t cpi_op;
	logic cpi_update;
	logic [7:0] ack_delay;
	logic resp_status;
	logic resp_update;
	logic [7:0] req_count;

	stim_row_t rows [32];
	int num_rows;
	int expected_requests;
	int checks;
	int errors;
	int timeouts;
	logic [31:0] lcg_state;

	// What each strand's entry should hold once accepted
	l1_store_pkg::tag_t exp_tag [4];
	l1_store_pkg::set_t exp_set [4];
	l1_store_pkg::line_data_t exp_data [4];
	l1_store_pkg::byte_mask_t exp_mask [4];
	l1_store_pkg::l2_op_t exp_op [4];

	store_path_top UUT (
		.clk(clk),
		.rst_n_i(rst_n),
		.write_i(write),
		.synchronized_i(synchronized),
		.strand_id_i(strand_id),
		.tag_i(tag),
		.set_i(set_idx),
		.data_i(data_in),
		.mask_i(mask_in),
		.data_o(data_out),
		.mask_o(mask_out),
		.rollback_o(rollback),
		.resume_strands_o(resume_strands),
		.store_update_o(store_update),
		.store_update_set_o(store_update_set),
		.pci_valid_o(pci_valid),
		.pci_ack_i(pci_ack),
		.pci_unit_o(pci_unit),
		.pci_strand_o(pci_strand),
		.pci_op_o(pci_op),
		.pci_address_o(pci_address),
		.pci_data_o(pci_data),
		.pci_mask_o(pci_mask),
		.cpi_valid_i(cpi_valid),
		.cpi_status_i(cpi_status),
		.cpi_unit_i(cpi_unit),
		.cpi_strand_i(cpi_strand),
		.cpi_op_i(cpi_op),
		.cpi_update_i(cpi_update)
	);

	l2_stub u_l2_stub (
		.clk(clk),
		.rst_n_i(rst_n),
		.pci_valid_i(pci_valid),
		.pci_strand_i(pci_strand),
		.ack_delay_i(ack_delay),
		.status_i(resp_status),
		.update_i(resp_update),
		.pci_ack_o(pci_ack),
		.cpi_valid_o(cpi_valid),
		.cpi_status_o(cpi_status),
		.cpi_unit_o(cpi_unit),
		.cpi_strand_o(cpi_strand),
		.cpi_op_o(cpi_op),
		.cpi_update_o(cpi_update),
		.req_count_o(req_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Sync store result with the status bit in the low bit of every word
	function automatic l1_store_pkg::line_data_t sync_line(input logic status);
		l1_store_pkg::line_data_t line;
		line = '0;
		for (int w = 0; w < l1_store_pkg::LINE_WIDTH / 32; w++)
		begin
			line[w * 32 +: 32] = {31'd0, status};
		end
		return line;
	endfunction

	task automatic check_value(input string name, input logic [511:0] actual,
		input logic [511:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Error: %s = 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timed out waiting for %s at %0t", what, $time);
	endtask

	task automatic add_row(input row_op_t op, input l1_store_pkg::strand_id_t strand,
		input l1_store_pkg::tag_t tag_v, input l1_store_pkg::set_t set_v,
		input l1_store_pkg::byte_mask_t mask, input logic [7:0] delay, input logic status,
		input logic update, input logic enq, input logic exp_rb, input check_t chk,
		input l1_store_pkg::strand_mask_t exp_resume);
		stim_row_t r;
		r.op = op;
		r.strand = strand;
		r.tag = tag_v;
		r.set_idx = set_v;
		for (int w = 0; w < l1_store_pkg::LINE_WIDTH / 32; w++)
		begin
			r.data[w * 32 +: 32] = next_random();
		end
		r.mask = mask;
		r.delay = delay;
		r.status = status;
		r.update = update;
		r.enq = enq;
		r.exp_rollback = exp_rb;
		r.chk = chk;
		r.exp_resume = exp_resume;
		rows[num_rows] = r;
		num_rows++;
		if (enq)
		begin
			expected_requests++;
		end
	endtask

	task automatic load_table();
		// op, strand, tag, set, mask, delay, status, update, enq, rollback, check, resume
		add_row(ROW_STORE, 2'd0, 21'h0abcd, 5'h03, 64'hff00ff00, 2, 0, 1, 1, 0, CHK_NONE, 4'h0);
		add_row(ROW_DRAIN, 2'd0, 21'h0, 5'h0, 64'h0, 2, 0, 1, 0, 0, CHK_NONE, 4'h0);
		// Long ack delay keeps strand 1 busy for the lookups and the rewrite
		add_row(ROW_STORE, 2'd1, 21'h1f00f, 5'h11, 64'hf0f0_00ff, 20, 0, 0, 1, 0, CHK_NONE, 4'h0);
		add_row(ROW_LOAD, 2'd1, 21'h1f00f, 5'h11, 64'h0, 20, 0, 0, 0, 0, CHK_HIT, 4'h0);
		add_row(ROW_LOAD, 2'd2, 21'h1f00f, 5'h11, 64'h0, 20, 0, 0, 0, 0, CHK_ZERO, 4'h0);
		add_row(ROW_LOAD, 2'd1, 21'h1f00e, 5'h11, 64'h0, 20, 0, 0, 0, 0, CHK_ZERO, 4'h0);
		add_row(ROW_LOAD, 2'd1, 21'h1f00f, 5'h12, 64'h0, 20, 0, 0, 0, 0, CHK_ZERO, 4'h0);
		add_row(ROW_STORE, 2'd1, 21'h00123, 5'h04, 64'h0f, 20, 0, 0, 0, 1, CHK_NONE, 4'h0);
		add_row(ROW_DRAIN, 2'd1, 21'h0, 5'h0, 64'h0, 20, 0, 0, 0, 0, CHK_NONE, 4'h2);
		add_row(ROW_LOAD, 2'd1, 21'h1f00f, 5'h11, 64'h0, 20, 0, 0, 0, 0, CHK_ZERO, 4'h0);
		// Synchronized store first try and retry
		add_row(ROW_SYNC, 2'd2, 21'h05555, 5'h1a, 64'h0f, 3, 1, 1, 1, 1, CHK_NONE, 4'h0);
		add_row(ROW_DRAIN, 2'd2, 21'h0, 5'h0, 64'h0, 3, 1, 1, 0, 0, CHK_NONE, 4'h4);
		add_row(ROW_SYNC, 2'd2, 21'h05555, 5'h1a, 64'h0f, 3, 1, 0, 0, 0, CHK_SYNC, 4'h0);
		add_row(ROW_LOAD, 2'd2, 21'h05555, 5'h1a, 64'h0, 3, 0, 0, 0, 0, CHK_ZERO, 4'h0);
		// Strand 1 issues alone and the other three queue behind it
		add_row(ROW_STORE, 2'd1, 21'h02468, 5'h08, 64'hff0000, 12, 0, 1, 1, 0, CHK_NONE, 4'h0);
		add_row(ROW_STORE, 2'd3, 21'h13579, 5'h1f, 64'hffff, 12, 0, 1, 1, 0, CHK_NONE, 4'h0);
		add_row(ROW_STORE, 2'd0, 21'h0aaaa, 5'h15, 64'h3c3c, 12, 0, 1, 1, 0, CHK_NONE, 4'h0);
		add_row(ROW_STORE, 2'd2, 21'h15555, 5'h0a, 64'h8001, 12, 0, 1, 1, 0, CHK_NONE, 4'h0);
		// Round-robin order after strand 1 is 2 then 3 then 0
		add_row(ROW_DRAIN, 2'd1, 21'h0, 5'h0, 64'h0, 12, 0, 1, 0, 0, CHK_NONE, 4'h0);
		add_row(ROW_DRAIN, 2'd2, 21'h0, 5'h0, 64'h0, 1, 0, 0, 0, 0, CHK_NONE, 4'h0);
		add_row(ROW_DRAIN, 2'd3, 21'h0, 5'h0, 64'h0, 0, 0, 1, 0, 0, CHK_NONE, 4'h0);
		add_row(ROW_DRAIN, 2'd0, 21'h0, 5'h0, 64'h0, 4, 0, 1, 0, 0, CHK_NONE, 4'h0);
	endtask

	task automatic apply_write(input stim_row_t r, input logic sync);
		ack_delay = r.delay;
		resp_status = r.status;
		resp_update = r.update;
		@(negedge clk);
		write = 1'b1;
		synchronized = sync;
		strand_id = r.strand;
		tag = r.tag;
		set_idx = r.set_idx;
		data_in = r.data;
		mask_in = r.mask;
		@(negedge clk);
		write = 1'b0;
		synchronized = 1'b0;
		check_value("rollback_o", rollback, r.exp_rollback);
		if (r.chk == CHK_SYNC)
		begin
			check_value("data_o", data_out, sync_line(r.status));
			check_value("mask_o", mask_out, {l1_store_pkg::MASK_WIDTH{1'b1}});
		end
		if (r.enq)
		begin
			exp_tag[r.strand] = r.tag;
			exp_set[r.strand] = r.set_idx;
			exp_data[r.strand] = r.data;
			exp_mask[r.strand] = r.mask;
			exp_op[r.strand] = sync ? l1_store_pkg::L2_OP_STORE_SYNC : l1_store_pkg::L2_OP_STORE;
		end
	endtask

	task automatic apply_load(input stim_row_t r);
		@(negedge clk);
		write = 1'b0;
		synchronized = 1'b0;
		strand_id = r.strand;
		tag = r.tag;
		set_idx = r.set_idx;
		@(negedge clk);
		if (r.chk == CHK_HIT)
		begin
			check_value("data_o", data_out, exp_data[r.strand]);
			check_value("mask_o", mask_out, exp_mask[r.strand]);
		end
		else
		begin
			check_value("data_o", data_out, 0);
			check_value("mask_o", mask_out, 0);
		end
	endtask

	task automatic run_drain(input stim_row_t r);
		int cnt;
		l1_store_pkg::line_addr_t hold_addr;
		l1_store_pkg::line_data_t hold_data;
		l1_store_pkg::byte_mask_t hold_mask;
		l1_store_pkg::l2_op_t hold_op;
		ack_delay = r.delay;
		resp_status = r.status;
		resp_update = r.update;
		cnt = 0;
		while (!pci_valid && cnt < WAIT_LIMIT)
		begin
			@(negedge clk);
			cnt++;
		end
		if (!pci_valid)
		begin
			report_timeout("an L2 store request");
		end
		else
		begin
			check_value("pci_unit_o", pci_unit, l1_store_pkg::STBUF_UNIT);
			check_value("pci_strand_o", pci_strand, r.strand);
			check_value("pci_op_o", pci_op, exp_op[r.strand]);
			check_value("pci_address_o", pci_address, {exp_tag[r.strand], exp_set[r.strand]});
			check_value("pci_data_o", pci_data, exp_data[r.strand]);
			check_value("pci_mask_o", pci_mask, exp_mask[r.strand]);
			hold_addr = pci_address;
			hold_data = pci_data;
			hold_mask = pci_mask;
			hold_op = pci_op;
			// Request holds until the L2 takes it
			cnt = 0;
			while (!pci_ack && cnt < WAIT_LIMIT)
			begin
				@(negedge clk);
				cnt++;
				check_value("pci_valid_o", pci_valid, 1'b1);
				check_value("pci_op_o", pci_op, hold_op);
				check_value("pci_address_o", pci_address, hold_addr);
				check_value("pci_data_o", pci_data, hold_data);
				check_value("pci_mask_o", pci_mask, hold_mask);
			end
			if (!pci_ack)
			begin
				report_timeout("the L2 ack");
			end
			else
			begin
				@(negedge clk);
				check_value("pci_valid_o", pci_valid, 1'b0);
				check_value("store_update_o", store_update, r.update);
				if (r.update)
				begin
					check_value("store_update_set_o", store_update_set, exp_set[r.strand]);
				end
				@(negedge clk);
				check_value("resume_strands_o", resume_strands, r.exp_resume);
			end
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		write = 1'b0;
		synchronized = 1'b0;
		strand_id = '0;
		tag = '0;
		set_idx = '0;
		data_in = '0;
		mask_in = '0;
		ack_delay = '0;
		resp_status = 1'b0;
		resp_update = 1'b0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		num_rows = 0;
		expected_requests = 0;
		lcg_state = 32'd46859;
		load_table();

		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("pci_valid_o", pci_valid, 1'b0);
		check_value("rollback_o", rollback, 1'b0);
		check_value("resume_strands_o", resume_strands, 0);
		check_value("store_update_o", store_update, 1'b0);

		for (int i = 0; i < num_rows; i++)
		begin
			case (rows[i].op)
				ROW_STORE: apply_write(rows[i], 1'b0);
				ROW_SYNC: apply_write(rows[i], 1'b1);
				ROW_LOAD: apply_load(rows[i]);
				default: run_drain(rows[i]);
			endcase
		end

		// Sync retry must not have issued anything
		check_value("req_count_o", req_count, expected_requests);

		$display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
		begin
			$display("RESULT: PASS");
		end
		else
		begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== logic/l1_store_pkg.sv ====
// L1 data cache store path definitions
// Widths, L2 channel encodings and shared types

package l1_store_pkg;

	// Strand count and cache geometry
	localparam int NUM_STRANDS = 4;
	localparam int TAG_WIDTH = 21;
	localparam int SET_WIDTH = 5;
	localparam int ADDR_WIDTH = TAG_WIDTH + SET_WIDTH;
	localparam int LINE_WIDTH = 512;
	localparam int MASK_WIDTH = LINE_WIDTH / 8;

	typedef logic [1:0] strand_id_t;
	typedef logic [NUM_STRANDS-1:0] strand_mask_t;

	typedef logic [TAG_WIDTH-1:0] tag_t;
	typedef logic [SET_WIDTH-1:0] set_t;
	typedef logic [ADDR_WIDTH-1:0] line_addr_t;
	typedef logic [LINE_WIDTH-1:0] line_data_t;
	typedef logic [MASK_WIDTH-1:0] byte_mask_t;

	// L2 channel fields
	typedef logic [1:0] unit_id_t;
	typedef logic [2:0] l2_op_t;
	typedef logic [1:0] resp_op_t;

	// Store buffer identity on the L2 request and response channels
	localparam unit_id_t STBUF_UNIT = 2'd2;

	localparam l2_op_t L2_OP_STORE = 3'd1;
	localparam l2_op_t L2_OP_STORE_SYNC = 3'd5;

	// Request issue FSM
	typedef enum logic
	{
		ISSUE_IDLE,
		ISSUE_WAIT_ACK
	} issue_state_t;

endpackage

// ==== logic/rr_arbiter4.sv ====
// Four-way round-robin arbiter
// Priority starts after the last winner and only moves when advanced

`timescale 1ns/10ps

module rr_arbiter4 (
	input logic clk,
	input logic rst_n_i,
	input l1_store_pkg::strand_mask_t req_i,
	input logic advance_i,
	output l1_store_pkg::strand_mask_t grant_o
);

	l1_store_pkg::strand_id_t last_winner;
	l1_store_pkg::strand_id_t grant_idx;
	l1_store_pkg::strand_id_t scan_idx;
	logic found;

	// Scan from the strand after the last winner, wrapping around
	always_comb
	begin
		grant_o = '0;
		grant_idx = last_winner;
		scan_idx = last_winner;
		found = 1'b0;
		for (int i = 1; i <= l1_store_pkg::NUM_STRANDS; i++)
		begin
			scan_idx = last_winner + l1_store_pkg::strand_id_t'(i);
			if (req_i[scan_idx] && !found)
			begin
				grant_o[scan_idx] = 1'b1;
				grant_idx = scan_idx;
				found = 1'b1;
			end
		end
	end

	// Last winner pointer, starts so that strand 0 has top priority
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			last_winner <= l1_store_pkg::strand_id_t'(l1_store_pkg::NUM_STRANDS - 1);
		end
		else if (advance_i && found)
		begin
			last_winner <= grant_idx;
		end
	end

endmodule

// ==== logic/store_buffer.sv ====
// Per-strand store buffer of the L1 data cache
// Queues one store per strand, issues to L2 and retires on response

`timescale 1ns/10ps

module store_buffer (
	input logic clk,
	input logic rst_n_i,
	input logic write_i,
	input logic synchronized_i,
	input l1_store_pkg::strand_id_t strand_id_i,
	input l1_store_pkg::tag_t tag_i,
	input l1_store_pkg::set_t set_i,
	input l1_store_pkg::line_data_t data_i,
	input l1_store_pkg::byte_mask_t mask_i,
	input logic sync_enqueue_i,
	input l1_store_pkg::strand_mask_t sync_resume_i,
	output l1_store_pkg::strand_mask_t entry_valid_o,
	output logic [l1_store_pkg::NUM_STRANDS*l1_store_pkg::TAG_WIDTH-1:0] entry_tag_o,
	output logic [l1_store_pkg::NUM_STRANDS*l1_store_pkg::SET_WIDTH-1:0] entry_set_o,
	output logic [l1_store_pkg::NUM_STRANDS*l1_store_pkg::LINE_WIDTH-1:0] entry_data_o,
	output logic [l1_store_pkg::NUM_STRANDS*l1_store_pkg::MASK_WIDTH-1:0] entry_mask_o,
	output l1_store_pkg::strand_mask_t entry_busy_o,
	output logic resp_done_o,
	output logic full_rollback_o,
	output l1_store_pkg::strand_mask_t resume_strands_o,
	output logic store_update_o,
	output l1_store_pkg::set_t store_update_set_o,
	output logic pci_valid_o,
	input logic pci_ack_i,
	output l1_store_pkg::unit_id_t pci_unit_o,
	output l1_store_pkg::strand_id_t pci_strand_o,
	output l1_store_pkg::l2_op_t pci_op_o,
	output l1_store_pkg::line_addr_t pci_address_o,
	output l1_store_pkg::line_data_t pci_data_o,
	output l1_store_pkg::byte_mask_t pci_mask_o,
	input logic cpi_valid_i,
	input logic cpi_status_i,
	input l1_store_pkg::unit_id_t cpi_unit_i,
	input l1_store_pkg::strand_id_t cpi_strand_i,
	input l1_store_pkg::resp_op_t cpi_op_i,
	input logic cpi_update_i,
	output l1_store_pkg::strand_mask_t arb_req_o,
	output logic arb_advance_o,
	input l1_store_pkg::strand_mask_t arb_grant_i
);

	// Entry payload
	l1_store_pkg::tag_t store_tag [l1_store_pkg::NUM_STRANDS];
	l1_store_pkg::set_t store_set [l1_store_pkg::NUM_STRANDS];
	l1_store_pkg::line_data_t store_data [l1_store_pkg::NUM_STRANDS];
	l1_store_pkg::byte_mask_t store_mask [l1_store_pkg::NUM_STRANDS];

	// Entry control
	l1_store_pkg::strand_mask_t store_enqueued;
	l1_store_pkg::strand_mask_t store_acked;
	l1_store_pkg::strand_mask_t store_sync;
	l1_store_pkg::strand_mask_t wait_strands;

	l1_store_pkg::issue_state_t issue_state;
	l1_store_pkg::strand_id_t issue_entry;
	l1_store_pkg::strand_id_t grant_idx;

	l1_store_pkg::strand_mask_t complete_mask;
	logic store_complete;
	logic collision;
	logic full;
	logic enqueue;

	// Response for the store buffer retires an occupied entry
	always_comb
	begin
		complete_mask = '0;
		if (cpi_valid_i && (cpi_unit_i == l1_store_pkg::STBUF_UNIT)
			&& store_enqueued[cpi_strand_i])
		begin
			complete_mask[cpi_strand_i] = 1'b1;
		end
	end

	assign store_complete = |complete_mask;
	assign resp_done_o = store_complete;

	// Rewrite in the response cycle takes over the entry
	assign collision = store_complete && write_i && (strand_id_i == cpi_strand_i);
	assign full = write_i && store_enqueued[strand_id_i] && !collision;
	assign enqueue = write_i && (!store_enqueued[strand_id_i] || collision)
		&& (!synchronized_i || sync_enqueue_i);

	assign store_update_o = store_complete && cpi_update_i;
	assign store_update_set_o = store_complete ? store_set[cpi_strand_i] : '0;

	// Export entries to the bypass and tracker
	assign entry_valid_o = store_enqueued;
	assign entry_busy_o = store_enqueued & ~complete_mask;

	always_comb
	begin
		for (int i = 0; i < l1_store_pkg::NUM_STRANDS; i++)
		begin
			entry_tag_o[i * l1_store_pkg::TAG_WIDTH +: l1_store_pkg::TAG_WIDTH] = store_tag[i];
			entry_set_o[i * l1_store_pkg::SET_WIDTH +: l1_store_pkg::SET_WIDTH] = store_set[i];
			entry_data_o[i * l1_store_pkg::LINE_WIDTH +: l1_store_pkg::LINE_WIDTH] = store_data[i];
			entry_mask_o[i * l1_store_pkg::MASK_WIDTH +: l1_store_pkg::MASK_WIDTH] = store_mask[i];
		end
	end

	// Arbitration between entries waiting to go out
	assign arb_req_o = store_enqueued & ~store_acked;
	assign arb_advance_o = (issue_state == l1_store_pkg::ISSUE_IDLE);

	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < l1_store_pkg::NUM_STRANDS; i++)
		begin
			if (arb_grant_i[i])
			begin
				grant_idx = l1_store_pkg::strand_id_t'(i);
			end
		end
	end

	// L2 request fields come straight from the latched entry
	assign pci_valid_o = (issue_state == l1_store_pkg::ISSUE_WAIT_ACK);
	assign pci_unit_o = l1_store_pkg::STBUF_UNIT;
	assign pci_strand_o = issue_entry;
	assign pci_op_o = store_sync[issue_entry] ? l1_store_pkg::L2_OP_STORE_SYNC
		: l1_store_pkg::L2_OP_STORE;
	assign pci_address_o = {store_tag[issue_entry], store_set[issue_entry]};
	assign pci_data_o = store_data[issue_entry];
	assign pci_mask_o = store_mask[issue_entry];

	always_ff @(posedge clk)
	begin
		if (enqueue)
		begin
			store_tag[strand_id_i] <= tag_i;
			store_set[strand_id_i] <= set_i;
			store_data[strand_id_i] <= data_i;
			store_mask[strand_id_i] <= mask_i;
		end
	end

	// Entry state and issue FSM
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			store_enqueued <= '0;
			store_acked <= '0;
			store_sync <= '0;
			issue_state <= l1_store_pkg::ISSUE_IDLE;
			issue_entry <= '0;
		end
		else
		begin
			case (issue_state)
				l1_store_pkg::ISSUE_IDLE:
				begin
					if (|arb_grant_i)
					begin
						issue_entry <= grant_idx;
						issue_state <= l1_store_pkg::ISSUE_WAIT_ACK;
					end
				end
				l1_store_pkg::ISSUE_WAIT_ACK:
				begin
					if (pci_ack_i)
					begin
						store_acked[issue_entry] <= 1'b1;
						issue_state <= l1_store_pkg::ISSUE_IDLE;
					end
				end
				default:
				begin
					issue_state <= l1_store_pkg::ISSUE_IDLE;
				end
			endcase

			if (store_complete)
			begin
				store_enqueued[cpi_strand_i] <= 1'b0;
				store_acked[cpi_strand_i] <= 1'b0;
			end

			// New store wins over a retirement of the same entry
			if (enqueue)
			begin
				store_enqueued[strand_id_i] <= 1'b1;
				store_acked[strand_id_i] <= 1'b0;
				store_sync[strand_id_i] <= synchronized_i;
			end
		end
	end

	// Full rollback and resume once the entry drains
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wait_strands <= '0;
			full_rollback_o <= 1'b0;
			resume_strands_o <= '0;
		end
		else
		begin
			wait_strands <= wait_strands & ~complete_mask;
			if (full)
			begin
				wait_strands[strand_id_i] <= 1'b1;
			end
			full_rollback_o <= full;
			resume_strands_o <= (complete_mask & wait_strands) | sync_resume_i;
		end
	end

endmodule

// ==== logic/store_path_top.sv ====
// L1 data cache store path top level
// Store buffer, issue arbiter, load bypass and sync store tracking

`timescale 1ns/10ps

module store_path_top (
	input logic clk,
	input logic rst_n_i,
	input logic write_i,
	input logic synchronized_i,
	input l1_store_pkg::strand_id_t strand_id_i,
	input l1_store_pkg::tag_t tag_i,
	input l1_store_pkg::set_t set_i,
	input l1_store_pkg::line_data_t data_i,
	input l1_store_pkg::byte_mask_t mask_i,
	output l1_store_pkg::line_data_t data_o,
	output l1_store_pkg::byte_mask_t mask_o,
	output logic rollback_o,
	output l1_store_pkg::strand_mask_t resume_strands_o,
	output logic store_update_o,
	output l1_store_pkg::set_t store_update_set_o,
	output logic pci_valid_o,
	input logic pci_ack_i,
	output l1_store_pkg::unit_id_t pci_unit_o,
	output l1_store_pkg::strand_id_t pci_strand_o,
	output l1_store_pkg::l2_op_t pci_op_o,
	output l1_store_pkg::line_addr_t pci_address_o,
	output l1_store_pkg::line_data_t pci_data_o,
	output l1_store_pkg::byte_mask_t pci_mask_o,
	input logic cpi_valid_i,
	input logic cpi_status_i,
	input l1_store_pkg::unit_id_t cpi_unit_i,
	input l1_store_pkg::strand_id_t cpi_strand_i,
	input l1_store_pkg::resp_op_t cpi_op_i,
	input logic cpi_update_i
);

	l1_store_pkg::strand_mask_t entry_valid;
	logic [l1_store_pkg::NUM_STRANDS*l1_store_pkg::TAG_WIDTH-1:0] entry_tag;
	logic [l1_store_pkg::NUM_STRANDS*l1_store_pkg::SET_WIDTH-1:0] entry_set;
	logic [l1_store_pkg::NUM_STRANDS*l1_store_pkg::LINE_WIDTH-1:0] entry_data;
	logic [l1_store_pkg::NUM_STRANDS*l1_store_pkg::MASK_WIDTH-1:0] entry_mask;
	l1_store_pkg::strand_mask_t entry_busy;
	l1_store_pkg::strand_mask_t arb_req;
	l1_store_pkg::strand_mask_t arb_grant;
	l1_store_pkg::strand_mask_t sync_status;
	l1_store_pkg::strand_mask_t sync_resume;
	logic arb_advance;
	logic resp_done;
	logic sync_enqueue;
	logic full_rollback;
	logic sync_rollback;

	// Either rollback source stalls the strand
	assign rollback_o = full_rollback | sync_rollback;

	store_buffer u_store_buffer (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.write_i(write_i),
		.synchronized_i(synchronized_i),
		.strand_id_i(strand_id_i),
		.tag_i(tag_i),
		.set_i(set_i),
		.data_i(data_i),
		.mask_i(mask_i),
		.sync_enqueue_i(sync_enqueue),
		.sync_resume_i(sync_resume),
		.entry_valid_o(entry_valid),
		.entry_tag_o(entry_tag),
		.entry_set_o(entry_set),
		.entry_data_o(entry_data),
		.entry_mask_o(entry_mask),
		.entry_busy_o(entry_busy),
		.resp_done_o(resp_done),
		.full_rollback_o(full_rollback),
		.resume_strands_o(resume_strands_o),
		.store_update_o(store_update_o),
		.store_update_set_o(store_update_set_o),
		.pci_valid_o(pci_valid_o),
		.pci_ack_i(pci_ack_i),
		.pci_unit_o(pci_unit_o),
		.pci_strand_o(pci_strand_o),
		.pci_op_o(pci_op_o),
		.pci_address_o(pci_address_o),
		.pci_data_o(pci_data_o),
		.pci_mask_o(pci_mask_o),
		.cpi_valid_i(cpi_valid_i),
		.cpi_status_i(cpi_status_i),
		.cpi_unit_i(cpi_unit_i),
		.cpi_strand_i(cpi_strand_i),
		.cpi_op_i(cpi_op_i),
		.cpi_update_i(cpi_update_i),
		.arb_req_o(arb_req),
		.arb_advance_o(arb_advance),
		.arb_grant_i(arb_grant)
	);

	rr_arbiter4 u_rr_arbiter4 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.req_i(arb_req),
		.advance_i(arb_advance),
		.grant_o(arb_grant)
	);

	store_raw_bypass u_store_raw_bypass (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.strand_id_i(strand_id_i),
		.tag_i(tag_i),
		.set_i(set_i),
		.write_i(write_i),
		.synchronized_i(synchronized_i),
		.entry_valid_i(entry_valid),
		.entry_tag_i(entry_tag),
		.entry_set_i(entry_set),
		.entry_data_i(entry_data),
		.entry_mask_i(entry_mask),
		.sync_status_i(sync_status),
		.data_o(data_o),
		.mask_o(mask_o)
	);

	sync_store_tracker u_sync_store_tracker (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.write_i(write_i),
		.synchronized_i(synchronized_i),
		.strand_id_i(strand_id_i),
		.entry_busy_i(entry_busy),
		.resp_done_i(resp_done),
		.resp_strand_i(cpi_strand_i),
		.resp_status_i(cpi_status_i),
		.sync_enqueue_o(sync_enqueue),
		.sync_status_o(sync_status),
		.sync_rollback_o(sync_rollback),
		.sync_resume_o(sync_resume)
	);

endmodule

// ==== logic/store_raw_bypass.sv ====
// Store-to-load bypass for the L1 data cache
// Returns a strand's own pending store data, or its sync store result

`timescale 1ns/10ps

module store_raw_bypass (
	input logic clk,
	input logic rst_n_i,
	input l1_store_pkg::strand_id_t strand_id_i,
	input l1_store_pkg::tag_t tag_i,
	input l1_store_pkg::set_t set_i,
	input logic write_i,
	input logic synchronized_i,
	input l1_store_pkg::strand_mask_t entry_valid_i,
	input logic [l1_store_pkg::NUM_STRANDS*l1_store_pkg::TAG_WIDTH-1:0] entry_tag_i,
	input logic [l1_store_pkg::NUM_STRANDS*l1_store_pkg::SET_WIDTH-1:0] entry_set_i,
	input logic [l1_store_pkg::NUM_STRANDS*l1_store_pkg::LINE_WIDTH-1:0] entry_data_i,
	input logic [l1_store_pkg::NUM_STRANDS*l1_store_pkg::MASK_WIDTH-1:0] entry_mask_i,
	input l1_store_pkg::strand_mask_t sync_status_i,
	output l1_store_pkg::line_data_t data_o,
	output l1_store_pkg::byte_mask_t mask_o
);

	l1_store_pkg::tag_t own_tag;
	l1_store_pkg::set_t own_set;
	l1_store_pkg::line_data_t own_data;
	l1_store_pkg::byte_mask_t own_mask;
	l1_store_pkg::line_data_t sync_data;
	logic hit;

	// Only the requesting strand's entry can match
	always_comb
	begin
		own_tag = entry_tag_i[strand_id_i * l1_store_pkg::TAG_WIDTH +: l1_store_pkg::TAG_WIDTH];
		own_set = entry_set_i[strand_id_i * l1_store_pkg::SET_WIDTH +: l1_store_pkg::SET_WIDTH];
		own_data = entry_data_i[strand_id_i * l1_store_pkg::LINE_WIDTH +: l1_store_pkg::LINE_WIDTH];
		own_mask = entry_mask_i[strand_id_i * l1_store_pkg::MASK_WIDTH +: l1_store_pkg::MASK_WIDTH];
		hit = entry_valid_i[strand_id_i] && (own_tag == tag_i) && (own_set == set_i);
	end

	// Status bit replicated into the low bit of every 32-bit word
	assign sync_data = {(l1_store_pkg::LINE_WIDTH / 32){31'd0, sync_status_i[strand_id_i]}};

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			data_o <= '0;
			mask_o <= '0;
		end
		else if (write_i && synchronized_i)
		begin
			data_o <= sync_data;
			mask_o <= '1;
		end
		else if (hit)
		begin
			data_o <= own_data;
			mask_o <= own_mask;
		end
		else
		begin
			data_o <= '0;
			mask_o <= '0;
		end
	end

endmodule

// ==== logic/sync_store_tracker.sv ====
// Synchronized store tracking per strand
// First try goes to L2 and rolls back, the retry picks up the L2 status

`timescale 1ns/10ps

module sync_store_tracker (
	input logic clk,
	input logic rst_n_i,
	input logic write_i,
	input logic synchronized_i,
	input l1_store_pkg::strand_id_t strand_id_i,
	input l1_store_pkg::strand_mask_t entry_busy_i,
	input logic resp_done_i,
	input l1_store_pkg::strand_id_t resp_strand_i,
	input logic resp_status_i,
	output logic sync_enqueue_o,
	output l1_store_pkg::strand_mask_t sync_status_o,
	output logic sync_rollback_o,
	output l1_store_pkg::strand_mask_t sync_resume_o
);

	l1_store_pkg::strand_mask_t sync_wait;
	l1_store_pkg::strand_mask_t sync_complete;
	l1_store_pkg::strand_mask_t sync_result;
	l1_store_pkg::strand_mask_t req_mask;
	l1_store_pkg::strand_mask_t resp_mask;
	l1_store_pkg::strand_mask_t first_try_mask;
	logic need_rollback;

	// Sync write from a strand whose entry is free
	always_comb
	begin
		req_mask = '0;
		if (write_i && synchronized_i && !entry_busy_i[strand_id_i])
		begin
			req_mask[strand_id_i] = 1'b1;
		end
	end

	always_comb
	begin
		resp_mask = '0;
		if (resp_done_i)
		begin
			resp_mask[resp_strand_i] = 1'b1;
		end
	end

	// No result on hand yet, so this is the first try
	assign first_try_mask = req_mask & ~sync_complete;
	assign need_rollback = |first_try_mask;
	assign sync_enqueue_o = need_rollback;

	assign sync_resume_o = sync_wait & resp_mask;
	assign sync_status_o = sync_result;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			sync_wait <= '0;
			sync_complete <= '0;
			sync_result <= '0;
			sync_rollback_o <= 1'b0;
		end
		else
		begin
			sync_wait <= (sync_wait & ~resp_mask) | first_try_mask;
			// Retry consumes the result
			sync_complete <= (sync_complete & ~req_mask) | (sync_wait & resp_mask);
			if (|(sync_wait & resp_mask))
			begin
				sync_result[resp_strand_i] <= resp_status_i;
			end
			sync_rollback_o <= need_rollback;
		end
	end

endmodule

// ==== verilog.f ====
logic/l1_store_pkg.sv
logic/rr_arbiter4.sv
logic/store_raw_bypass.sv
logic/sync_store_tracker.sv
logic/store_buffer.sv
logic/store_path_top.sv
dv/l2_stub.sv
dv/store_path_tb.sv
